//--- design/m68k_bus_pkg.sv
`default_nettype none

package m68k_bus_pkg;

    // Address and data widths of the 68000 bus
    typedef logic [23:1] bus_addr_t;                // Word address, A0 is implied by the strobes
    typedef logic [15:0] bus_data_t;                // One bus word
    typedef logic [1:0]  byte_en_t;                 // Bit 1 upper byte, bit 0 lower byte
    typedef logic [2:0]  fc_t;                      // Function code FC2..FC0
    typedef logic [2:0]  ipl_t;                     // Interrupt level, 0 is none

    // Host transaction, 45 bits
    typedef struct packed {
        bus_addr_t addr;                            // Target word address
        logic      we;                              // High for a write cycle
        byte_en_t  be;                              // Selects UDS and LDS
        bus_data_t wdata;                           // Write payload
        fc_t       fc;                              // Placed on FC pins during the cycle
    } bus_req_t;

    // Host response, 17 bits
    typedef struct packed {
        bus_data_t rdata;                           // Captured at DTACK
        logic      was_write;                       // Echo of the request's we
    } bus_rsp_t;

    // Bridge sequencer states
    typedef enum logic [2:0] {
        IDLE,                                       // Waiting for host request
        ADDR,                                       // Address and RW on the bus
        STROBE,                                     // AS and data strobes low
        WAIT_ACK,                                   // Holding strobes until DTACK
        RELEASE,                                    // Strobes back high
        RESP                                        // Response offered to host
    } bridge_state_t;

    // SRAM slave geometry
    localparam int SRAM_AW    = 8;                  // Decoded word-address bits
    localparam int SRAM_WAIT  = 2;                  // Clocks from strobes seen to DTACK
    localparam int SRAM_CNT_W = $clog2(SRAM_WAIT + 1); // Wait counter width

    // Interrupt inputs
    localparam int NUM_IRQ = 7;                     // Lines 1..7 on irq[0]..irq[6]

endpackage

`default_nettype wire

//--- design/irq_priority_encoder.sv
`default_nettype none

module irq_priority_encoder (
    input  wire                               clk,
    input  wire                               rst,
    input  wire [m68k_bus_pkg::NUM_IRQ-1:0]   irq,
    output m68k_bus_pkg::ipl_t                ipl_n
);
    import m68k_bus_pkg::*;

    logic [NUM_IRQ-1:0] irq_s1;                     // First synchronizer stage
    logic [NUM_IRQ-1:0] irq_s2;                     // Second stage, safe to decode
    ipl_t               level;                      // Highest active line

    // Later lines override earlier ones
    always_comb begin
        level = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (irq_s2[i]) level = ipl_t'(i + 1);   // irq[i] is line i+1
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_s1 <= '0;
            irq_s2 <= '0;
            ipl_n  <= '1;                           // Level 0 on the pins
        end else begin
            irq_s1 <= irq;
            irq_s2 <= irq_s1;
            ipl_n  <= ~level;                       // Active-low code
        end
    end

endmodule

`default_nettype wire

//--- design/m68k_sram_slave.sv
`default_nettype none

module m68k_sram_slave (
    input  wire                          clk,
    input  wire                          rst,
    input  wire m68k_bus_pkg::bus_addr_t eab,
    input  wire                          as_n,
    input  wire                          uds_n,
    input  wire                          lds_n,
    input  wire                          rw_n,
    input  wire m68k_bus_pkg::bus_data_t data_out,
    output logic                         dtack_n,
    output m68k_bus_pkg::bus_data_t      data_in
);
    import m68k_bus_pkg::*;

    bus_data_t              mem [0:(1 << SRAM_AW) - 1]; // Word storage
    logic [SRAM_AW-1:0]     word_idx;               // Low address bits, upper ones alias
    logic [SRAM_CNT_W-1:0]  wait_cnt;               // Clocks since strobes seen
    logic                   strobed;                // AS with at least one data strobe
    logic                   hit;                    // Wait done, access this clock

    assign word_idx = eab[SRAM_AW:1];
    assign strobed  = ~as_n & (~uds_n | ~lds_n);
    assign hit      = strobed & dtack_n & (wait_cnt == SRAM_CNT_W'(SRAM_WAIT));

    // Wait-state counter and DTACK
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
            dtack_n  <= 1'b1;
        end else if (as_n) begin
            wait_cnt <= '0;                         // Cycle over, get ready for the next
            dtack_n  <= 1'b1;
        end else if (hit) begin
            dtack_n  <= 1'b0;                       // Held until AS rises
        end else if (strobed && dtack_n) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Memory access on the DTACK edge
    always_ff @(posedge clk) begin
        if (hit) begin
            if (!rw_n) begin
                if (!uds_n) mem[word_idx][15:8] <= data_out[15:8]; // Upper byte lane
                if (!lds_n) mem[word_idx][7:0]  <= data_out[7:0];  // Lower byte lane
            end else begin
                data_in <= mem[word_idx];           // Valid with DTACK low
            end
        end
    end

    // DTACK may trail AS by one clock only
    a_dtack_follows_as: assert property (
        @(posedge clk) disable iff (rst) !dtack_n |-> (!as_n || $past(!as_n))
    ) else $error("DTACK held after AS released");

endmodule

`default_nettype wire

//--- design/m68k_bus_bridge.sv
`default_nettype none

module m68k_bus_bridge (
    input  wire                          clk,
    input  wire                          rst,
    // Host request side
    input  wire m68k_bus_pkg::bus_req_t  req,
    input  wire                          req_valid,
    output logic                         req_ready,
    // Host response side
    output m68k_bus_pkg::bus_rsp_t       rsp,
    output logic                         rsp_valid,
    input  wire                          rsp_ready,
    // 68000 bus
    output m68k_bus_pkg::bus_addr_t      eab,
    output logic                         as_n,
    output logic                         uds_n,
    output logic                         lds_n,
    output logic                         rw_n,
    input  wire                          dtack_n,
    input  wire m68k_bus_pkg::bus_data_t data_in,
    output m68k_bus_pkg::bus_data_t      data_out,
    output m68k_bus_pkg::fc_t            fc,
    // Bus arbitration
    input  wire                          br_n,
    input  wire                          bgack_n,
    output logic                         bg_n
);
    import m68k_bus_pkg::*;

    bridge_state_t state;                           // Sequencer state
    bus_req_t      req_q;                           // Latched transaction
    logic          cen;                             // Half-rate step enable
    logic          run;                             // Set one clock after reset
    logic          bus_busy;                        // Strobes out, no DTACK yet
    logic          accept;                          // Host handshake this clock
    logic          ack;                             // DTACK taken on an enabled step
    logic          cyc_active;                      // Between accept and release

    assign accept     = req_valid & req_ready;
    assign ack        = (state == WAIT_ACK) & cen & ~dtack_n;
    assign cyc_active = (state != IDLE) & (state != RESP);

    // No new work while a master asks for the bus or holds it
    assign req_ready = run & (state == IDLE) & bg_n & br_n;
    assign rsp_valid = (state == RESP);

    assign eab      = req_q.addr;
    assign data_out = req_q.wdata;
    assign fc       = req_q.fc;
    assign as_n     = ~bus_busy;
    assign uds_n    = ~(bus_busy & req_q.be[1]);    // Upper byte D15..D8
    assign lds_n    = ~(bus_busy & req_q.be[0]);    // Lower byte D7..D0
    assign rw_n     = ~(req_q.we & cyc_active);     // Low for the whole write cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            cen <= 1'b0;
            run <= 1'b0;
        end else begin
            cen <= ~cen & bg_n & bgack_n;           // Frozen while another master owns the bus
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            bus_busy <= 1'b0;
        end else begin
            case (state)
                IDLE:     if (accept) state <= ADDR;
                ADDR: begin
                    if (cen) begin
                        state    <= STROBE;
                        bus_busy <= 1'b1;           // Address has had a full step
                    end
                end
                STROBE:   if (cen) state <= WAIT_ACK;
                WAIT_ACK: begin
                    if (ack) begin
                        state    <= RELEASE;
                        bus_busy <= 1'b0;           // All strobes rise together
                    end
                end
                RELEASE:  if (cen) state <= RESP;
                RESP:     if (rsp_ready) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
        if (ack) begin
            rsp.rdata     <= req_q.we ? req_q.wdata : data_in; // Writes echo their data
            rsp.was_write <= req_q.we;
        end
    end

    // Grant only between cycles
    always_ff @(posedge clk) begin
        if (rst) bg_n <= 1'b1;
        else if (br_n) bg_n <= 1'b1;
        else if ((state == IDLE) && !bus_busy) bg_n <= 1'b0;
    end

    a_no_as_when_granted: assert property (
        @(posedge clk) disable iff (rst) !bg_n |-> as_n
    ) else $error("AS asserted while bus granted away");

    a_ds_within_as: assert property (
        @(posedge clk) disable iff (rst) (!uds_n || !lds_n) |-> !as_n
    ) else $error("Data strobe low without AS");

endmodule

`default_nettype wire

//--- design/m68k_subsystem_top.sv
`default_nettype none

module m68k_subsystem_top (
    input  wire                             clk,
    input  wire                             rst,
    // Host ports
    input  wire m68k_bus_pkg::bus_req_t     req,
    input  wire                             req_valid,
    output m68k_bus_pkg::bus_rsp_t          rsp,
    output logic                            req_ready,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    // Arbitration
    input  wire                             br_n,
    input  wire                             bgack_n,
    output logic                            bg_n,
    // Interrupts and status
    input  wire [m68k_bus_pkg::NUM_IRQ-1:0] irq,
    output m68k_bus_pkg::ipl_t              ipl_n,
    output m68k_bus_pkg::fc_t               fc
);
    import m68k_bus_pkg::*;

    // 68000 bus nets
    wire bus_addr_t eab;                            // A23..A1
    wire bus_data_t data_out;                       // Bridge to slave
    wire bus_data_t data_in;                        // Slave to bridge
    wire            as_n;
    wire            uds_n;
    wire            lds_n;
    wire            rw_n;
    wire            dtack_n;

    m68k_bus_bridge u_bridge (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .eab       (eab),
        .as_n      (as_n),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .rw_n      (rw_n),
        .dtack_n   (dtack_n),
        .data_in   (data_in),
        .data_out  (data_out),
        .fc        (fc),
        .br_n      (br_n),
        .bgack_n   (bgack_n),
        .bg_n      (bg_n)
    );

    m68k_sram_slave u_sram (
        .clk      (clk),
        .rst      (rst),
        .eab      (eab),
        .as_n     (as_n),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .rw_n     (rw_n),
        .data_out (data_out),
        .dtack_n  (dtack_n),
        .data_in  (data_in)
    );

    irq_priority_encoder u_irq (
        .clk   (clk),
        .rst   (rst),
        .irq   (irq),
        .ipl_n (ipl_n)
    );

endmodule

`default_nettype wire

//--- sim/m68k_subsystem_tb.sv
`default_nettype none

module m68k_subsystem_tb;
    import m68k_bus_pkg::*;

    localparam string STIM_FILE    = "sim/m68k_stimulus.txt";
    localparam int    LINE_BUDGET  = 200;           // Watchdog clocks per stimulus line
    localparam fc_t   FC_SUP_DATA  = 3'b101;        // Supervisor data space
    localparam fc_t   FC_USER_DATA = 3'b001;        // User data space

    logic               clk;
    logic               rst;
    bus_req_t           req;
    logic               req_valid;
    logic               req_ready;
    bus_rsp_t           rsp;
    logic               rsp_valid;
    logic               rsp_ready;
    logic               br_n;
    logic               bgack_n;
    logic               bg_n;
    logic [NUM_IRQ-1:0] irq;
    ipl_t               ipl_n;
    fc_t                fc;

    bus_data_t          shadow [0:(1 << SRAM_AW) - 1]; // Reference copy of the SRAM
    logic [31:0]        lfsr;                       // Idle gap source
    int                 errors;
    int                 ops;
    int                 err_before;
    int                 num_lines;
    int                 limit_cycles;               // Zero until the file is counted
    int                 cur_level;                  // Level last seen on ipl_n
    int                 pend_bp;                    // Back-pressure for the next W or R
    int                 scan;
    int                 fd;
    logic [7:0]         f_op;
    logic [31:0]        f_a;
    logic [31:0]        f_b;
    logic [31:0]        f_c;
    logic [8*256-1:0]   line_buf;
    bus_rsp_t           got;
    string              desc;

    m68k_subsystem_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .br_n      (br_n),
        .bgack_n   (bgack_n),
        .bg_n      (bg_n),
        .irq       (irq),
        .ipl_n     (ipl_n),
        .fc        (fc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Highest set line wins, line n sits on irq[n-1]
    function automatic int top_line(input logic [NUM_IRQ-1:0] m);
        for (int n = NUM_IRQ; n >= 1; n--) begin
            if (m[n-1]) return n;
        end
        return 0;
    endfunction

    function automatic bus_req_t make_req(input bus_addr_t a, input logic we,
                                          input byte_en_t be, input bus_data_t d);
        bus_req_t r;
        r.addr  = a;
        r.we    = we;
        r.be    = be;
        r.wdata = d;
        r.fc    = we ? FC_USER_DATA : FC_SUP_DATA; // FC pins change between W and R
        return r;
    endfunction

    task automatic value_error(input string msg);
        $display("ERR t=%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("At time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic need_fields(input int got_n, input int want_n);
        if (got_n != want_n) note_failure("stimulus line has the wrong number of fields");
    endtask

    task automatic idle_gap();
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);                 // One step per bit
            gap  = gap * 2 + int'(lfsr[0]);
        end
        repeat (gap) @(posedge clk);
    endtask

    task automatic drive_req(input bus_req_t r, input int bp);
        @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
        if (bp > 0) rsp_ready <= 1'b0;              // Host stalls the answer
    endtask

    task automatic wait_accept();
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);                             // Transfer edge
        req_valid <= 1'b0;
    endtask

    task automatic wait_rsp(input int bp, output bus_rsp_t held);
        int lat;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (!bg_n) note_failure("bus was granted while a cycle was in flight");
        end while (!rsp_valid);
        if (lat > 12) note_failure($sformatf("response took %0d clocks, more than 12", lat));
        held = rsp;
        repeat (bp) begin
            @(negedge clk);
            if (!rsp_valid || rsp !== held) note_failure("response moved during back-pressure");
            if (req_ready) note_failure("request port opened during back-pressure");
        end
        if (bp > 0) begin
            @(posedge clk);
            rsp_ready <= 1'b1;
        end
        @(posedge clk);                             // Response handshake edge
    endtask

    task automatic do_transfer(input bus_req_t r, input int bp, output bus_rsp_t held);
        drive_req(r, bp);
        wait_accept();
        wait_rsp(bp, held);
        if (fc !== r.fc) value_error($sformatf("fc %b, expected %b", fc, r.fc));
    endtask

    // Write in flight when BR falls, read parked until BR rises
    task automatic run_grant(input bus_addr_t a, input bus_data_t d, input int hold);
        bus_rsp_t held;
        int       n;
        drive_req(make_req(a, 1'b1, 2'b11, d), 0);
        wait_accept();
        br_n <= 1'b0;
        wait_rsp(0, held);
        shadow[a[SRAM_AW:1]] = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (req_ready) note_failure("request port open while the bus was requested");
        end while (bg_n && n < 4);
        if (bg_n) note_failure("bus grant never arrived after the cycle ended");
        drive_req(make_req(a, 1'b0, 2'b11, '0), 0);
        repeat (hold) begin
            @(negedge clk);
            if (req_ready) note_failure("request accepted while the bus was granted");
            if (bg_n) note_failure("bus grant dropped while BR was still low");
        end
        @(posedge clk);
        br_n <= 1'b1;
        wait_accept();
        wait_rsp(0, held);
        if (held.rdata !== d) value_error($sformatf("read %h after grant, expected %h",
                                                     held.rdata, d));
    endtask

    task automatic run_irq(input logic [NUM_IRQ-1:0] mask, input int file_lvl);
        int         lvl;
        logic [2:0] prev_ipl;
        lvl      = top_line(mask);
        prev_ipl = ~3'(cur_level);
        if (file_lvl != lvl) note_failure("stimulus level disagrees with the irq mask");
        @(posedge clk);
        irq <= mask;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (ipl_n !== prev_ipl) value_error($sformatf("ipl_n %b moved before 3 clocks", ipl_n));
        @(posedge clk);
        @(negedge clk);
        if (ipl_n !== ~3'(lvl)) value_error($sformatf("ipl_n %b, expected %b", ipl_n, ~3'(lvl)));
        cur_level = lvl;
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d clocks, the run stalled", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst       <= 1'b1;
        req       <= '0;
        req_valid <= 1'b0;
        rsp_ready <= 1'b1;
        br_n      <= 1'b1;
        bgack_n   <= 1'b1;
        irq       <= '0;
        lfsr      = 32'h9f51;
        fd        = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                scan = $fgets(line_buf, fd);
                if (scan > 0) num_lines++;
            end
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");            // Second pass runs the operations
        end else begin
            note_failure("could not open the stimulus file");
        end
        limit_cycles = (num_lines + 1) * LINE_BUDGET + 32;
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (req_ready || rsp_valid || !bg_n || ipl_n !== 3'b111)
            value_error("outputs not at their reset values");
        @(posedge clk);
        rst <= 1'b0;
        while (fd != 0 && !$feof(fd)) begin
            scan = $fscanf(fd, " %c", f_op);
            if (scan != 1) break;
            if (f_op == "#") begin
                scan = $fgets(line_buf, fd);        // Column notes
                continue;
            end
            ops++;
            err_before = errors;
            case (f_op)
                "W": begin
                    need_fields($fscanf(fd, "%h %h %h", f_a, f_b, f_c), 3);
                    idle_gap();
                    do_transfer(make_req(f_a[22:0], 1'b1, f_b[1:0], f_c[15:0]), pend_bp, got);
                    pend_bp = 0;
                    if (!got.was_write) value_error("write answered as a read");
                    if (f_b[1]) shadow[f_a[SRAM_AW-1:0]][15:8] = f_c[15:8];
                    if (f_b[0]) shadow[f_a[SRAM_AW-1:0]][7:0] = f_c[7:0];
                    desc = $sformatf("W %h be %b %h", f_a[22:0], f_b[1:0], f_c[15:0]);
                end
                "R": begin
                    need_fields($fscanf(fd, "%h %h", f_a, f_b), 2);
                    if (shadow[f_a[SRAM_AW-1:0]] !== f_b[15:0])
                        note_failure("file expectation disagrees with the shadow memory");
                    idle_gap();
                    do_transfer(make_req(f_a[22:0], 1'b0, 2'b11, '0), pend_bp, got);
                    pend_bp = 0;
                    if (got.rdata !== f_b[15:0] || got.was_write)
                        value_error($sformatf("read %h at %h, expected %h",
                                              got.rdata, f_a[22:0], f_b[15:0]));
                    desc = $sformatf("R %h %h", f_a[22:0], f_b[15:0]);
                end
                "G": begin
                    need_fields($fscanf(fd, "%h %h %h", f_a, f_b, f_c), 3);
                    idle_gap();
                    run_grant(f_a[22:0], f_b[15:0], int'(f_c));
                    desc = $sformatf("G %h hold %0d", f_a[22:0], f_c);
                end
                "I": begin
                    need_fields($fscanf(fd, "%h %h", f_a, f_b), 2);
                    run_irq(f_a[NUM_IRQ-1:0], int'(f_b));
                    desc = $sformatf("I mask %h level %0d", f_a[NUM_IRQ-1:0], f_b);
                end
                "P": begin
                    need_fields($fscanf(fd, "%h", f_a), 1);
                    pend_bp = int'(f_a[7:0]);
                    desc    = $sformatf("P %0d", pend_bp);
                end
                default: begin
                    note_failure($sformatf("unknown operation letter %c", f_op));
                    desc = "unknown";
                end
            endcase
            $display("op %0d %s: %s", ops, desc, (errors == err_before) ? "pass" : "fail");
        end
        $display("Operations run: %0d, failed checks: %0d", ops, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/m68k_stimulus.txt
# W addr be data | R addr expected | G addr data hold | I irq_mask level
# P cycles holds rsp_ready low on the next W or R; all fields hex, addr is a word address
W 000010 3 1234
W 000020 3 abcd
W 0000ff 3 5a5a
W 000001 3 0f0f
R 000010 1234
R 000020 abcd
R 0000ff 5a5a
R 000001 0f0f
R 000110 1234
R 7fff20 abcd
R 400001 0f0f
W 000010 2 ff00
R 000010 ff34
W 000020 1 0077
R 000020 ab77
W 000110 1 0099
R 000010 ff99
P 5
R 0000ff 5a5a
R 000001 0f0f
P 3
W 000040 3 c3c3
R 000040 c3c3
G 000050 9876 4
R 000050 9876
G 000060 1357 8
I 01 1
I 03 2
I 40 7
I 00 0
I 24 6
I 18 5
I 7f 7
R 000060 1357

//--- m68k_subsystem_top.f
design/m68k_bus_pkg.sv
design/irq_priority_encoder.sv
design/m68k_sram_slave.sv
design/m68k_bus_bridge.sv
design/m68k_subsystem_top.sv
sim/m68k_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the m68k subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing --assert -j 0 \
    --top-module m68k_subsystem_tb \
    -Mdir build -o m68k_sim \
    -f m68k_subsystem_top.f

status=0
./build/m68k_sim > build/sim.log 2>&1 || status=$?
cat build/sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" build/sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"
